// ==== include/soc_cfg.svh ====
// Word-addressed bus only; the memory map assumes region decode on the top four address bits
`ifndef SOC_CFG_SVH
`define SOC_CFG_SVH

//////////////////////////////////////////////////////////////////////
// Bus widths
//////////////////////////////////////////////////////////////////////

// Word address, no byte lanes
`define SOC_ADDR_W 16
`define SOC_DATA_W 32

//////////////////////////////////////////////////////////////////////
// Memory map
//////////////////////////////////////////////////////////////////////

`define SOC_MEM_DEPTH 256
`define SOC_MEM_IDX_W 8

// Region field in the word address
`define SOC_REGION_MSB 15
`define SOC_REGION_LSB 12

`define SOC_REGION_MEM  0
`define SOC_REGION_CTRL 1
`define SOC_REGION_EXT  2

//////////////////////////////////////////////////////////////////////
// Misc
//////////////////////////////////////////////////////////////////////

`define SOC_ID_VALUE 32'h5CE0_0001
`define SOC_RTC_SYNC_STAGES 2

// Extension block write counter, wraps
`define SOC_EXT_CNT_W 8

`endif

// ==== logic/soc_pkg.sv ====
// Bus types for the fixture; the request carries no byte strobes and there is no ready signal
`include "soc_cfg.svh"

package soc_pkg;

  // Widths with a meaning
  typedef logic [`SOC_ADDR_W-1:0] addr_t;
  typedef logic [`SOC_DATA_W-1:0] data_t;
  typedef logic [1:0]             boot_mode_t;

  //////////////////////////////////////////////////////////////////////
  // Host bus
  //////////////////////////////////////////////////////////////////////

  // One-cycle strobe per request
  typedef struct packed {
    logic  valid;
    logic  write;
    addr_t addr;
    data_t wdata;
  } bus_req_t;

  // Valid exactly one cycle after the request edge
  typedef struct packed {
    logic  valid;
    logic  err;
    data_t rdata;
  } bus_rsp_t;

  // Decoded target of a request
  typedef enum logic [1:0] {
    REG_MEM,
    REG_CTRL,
    REG_EXT,
    REG_NONE
  } region_e;

endpackage

// ==== logic/soc_scratch_mem.sv ====
// Contents are not reset and read X until written; only the low index bits of the address are used
`include "soc_cfg.svh"

module soc_scratch_mem (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  soc_pkg::bus_req_t req_i,
  output soc_pkg::bus_rsp_t rsp_o
);

  soc_pkg::data_t mem_q [`SOC_MEM_DEPTH];

  logic [`SOC_MEM_IDX_W-1:0] idx;
  logic                      rsp_valid_q;
  soc_pkg::data_t            rdata_q;

  assign idx = req_i.addr[`SOC_MEM_IDX_W-1:0];

  // Storage and read data
  always_ff @(posedge clk_i) begin
    if (req_i.valid) begin
      if (req_i.write) begin
        mem_q[idx] <= req_i.wdata;
        rdata_q    <= '0;
      end else begin
        rdata_q <= mem_q[idx];
      end
    end
  end

  // One cycle of latency for every request
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= req_i.valid;
    end
  end

  always_comb begin
    rsp_o.valid = rsp_valid_q;
    rsp_o.err   = 1'b0;
    rsp_o.rdata = rdata_q;
  end

endmodule

// ==== logic/soc_ctrl_regs.sv ====
// Only offsets 0 to 3 exist; writes to read-only offsets are dropped silently, rtc_i may be async
`include "soc_cfg.svh"

module soc_ctrl_regs (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                rtc_i,
  input  soc_pkg::boot_mode_t boot_mode_i,
  input  soc_pkg::bus_req_t   req_i,
  output soc_pkg::bus_rsp_t   rsp_o
);

  logic [`SOC_REGION_LSB-1:0]      offset;
  logic [`SOC_RTC_SYNC_STAGES-1:0] rtc_sync_q;
  logic                            rtc_prev_q;
  logic                            rtc_rise;

  soc_pkg::data_t rtc_cnt_q;
  soc_pkg::data_t scratch_q;
  soc_pkg::data_t rd_data;
  soc_pkg::data_t rdata_q;
  logic           bad_off;
  logic           rsp_valid_q;
  logic           rsp_err_q;

  assign offset = req_i.addr[`SOC_REGION_LSB-1:0];

  //////////////////////////////////////////////////////////////////////
  // RTC tick counter
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rtc_sync_q <= '0;
      rtc_prev_q <= 1'b0;
    end else begin
      rtc_sync_q <= {rtc_sync_q[`SOC_RTC_SYNC_STAGES-2:0], rtc_i};
      rtc_prev_q <= rtc_sync_q[`SOC_RTC_SYNC_STAGES-1];
    end
  end

  // Rising edge after the synchronizer
  assign rtc_rise = rtc_sync_q[`SOC_RTC_SYNC_STAGES-1] & ~rtc_prev_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rtc_cnt_q <= '0;
    end else if (rtc_rise) begin
      rtc_cnt_q <= rtc_cnt_q + 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Register file
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      scratch_q <= '0;
    end else if (req_i.valid && req_i.write && offset == 2) begin
      scratch_q <= req_i.wdata;
    end
  end

  // Read mux and offset check
  always_comb begin
    rd_data = '0;
    bad_off = 1'b0;
    case (offset)
      0:       rd_data = `SOC_ID_VALUE;
      1:       rd_data = soc_pkg::data_t'(boot_mode_i);
      2:       rd_data = scratch_q;
      3:       rd_data = rtc_cnt_q;
      default: bad_off = 1'b1;
    endcase
  end

  // Response, one cycle after the request
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
      rsp_err_q   <= 1'b0;
    end else begin
      rsp_valid_q <= req_i.valid;
      rsp_err_q   <= req_i.valid & bad_off;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.valid) begin
      rdata_q <= (req_i.write || bad_off) ? '0 : rd_data;
    end
  end

  always_comb begin
    rsp_o.valid = rsp_valid_q;
    rsp_o.err   = rsp_err_q;
    rsp_o.rdata = rdata_q;
  end

endmodule

// ==== logic/soc_core.sv ====
// Targets must answer exactly one cycle after the request; the core holds no response buffer
`include "soc_cfg.svh"

module soc_core (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                rtc_i,
  input  soc_pkg::boot_mode_t boot_mode_i,
  input  soc_pkg::bus_req_t   host_req_i,
  output soc_pkg::bus_rsp_t   host_rsp_o,
  output soc_pkg::bus_req_t   ext_slv_req_o,
  input  soc_pkg::bus_rsp_t   ext_slv_rsp_i
);

  logic [`SOC_REGION_MSB-`SOC_REGION_LSB:0] region_fld;
  logic [`SOC_REGION_LSB-1:`SOC_MEM_IDX_W]  mem_hole;

  soc_pkg::region_e  region;
  soc_pkg::region_e  region_q;
  logic              err_valid_q;
  soc_pkg::bus_req_t mem_req;
  soc_pkg::bus_req_t ctrl_req;
  soc_pkg::bus_rsp_t mem_rsp;
  soc_pkg::bus_rsp_t ctrl_rsp;

  //////////////////////////////////////////////////////////////////////
  // Address decode
  //////////////////////////////////////////////////////////////////////

  assign region_fld = host_req_i.addr[`SOC_REGION_MSB:`SOC_REGION_LSB];
  // Bits above the memory index inside the memory region
  assign mem_hole   = host_req_i.addr[`SOC_REGION_LSB-1:`SOC_MEM_IDX_W];

  always_comb begin
    case (region_fld)
      `SOC_REGION_MEM:  region = (mem_hole == '0) ? soc_pkg::REG_MEM : soc_pkg::REG_NONE;
      `SOC_REGION_CTRL: region = soc_pkg::REG_CTRL;
      `SOC_REGION_EXT:  region = soc_pkg::REG_EXT;
      default:          region = soc_pkg::REG_NONE;
    endcase
  end

  // Only the addressed target sees valid
  always_comb begin
    mem_req        = host_req_i;
    ctrl_req       = host_req_i;
    ext_slv_req_o  = host_req_i;
    mem_req.valid       = host_req_i.valid && region == soc_pkg::REG_MEM;
    ctrl_req.valid      = host_req_i.valid && region == soc_pkg::REG_CTRL;
    ext_slv_req_o.valid = host_req_i.valid && region == soc_pkg::REG_EXT;
  end

  //////////////////////////////////////////////////////////////////////
  // Response path
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      region_q    <= soc_pkg::REG_NONE;
      err_valid_q <= 1'b0;
    end else begin
      err_valid_q <= host_req_i.valid && region == soc_pkg::REG_NONE;
      if (host_req_i.valid) begin
        region_q <= region;
      end
    end
  end

  // In-order select, one request in flight per cycle
  always_comb begin
    case (region_q)
      soc_pkg::REG_MEM:  host_rsp_o = mem_rsp;
      soc_pkg::REG_CTRL: host_rsp_o = ctrl_rsp;
      soc_pkg::REG_EXT:  host_rsp_o = ext_slv_rsp_i;
      default: begin
        host_rsp_o.valid = err_valid_q;
        host_rsp_o.err   = err_valid_q;
        host_rsp_o.rdata = '0;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Internal targets
  //////////////////////////////////////////////////////////////////////

  soc_scratch_mem soc_scratch_mem_i (
    .clk_i   ( clk_i   ),
    .rst_n_i ( rst_n_i ),
    .req_i   ( mem_req ),
    .rsp_o   ( mem_rsp )
  );

  soc_ctrl_regs soc_ctrl_regs_i (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .rtc_i       ( rtc_i       ),
    .boot_mode_i ( boot_mode_i ),
    .req_i       ( ctrl_req    ),
    .rsp_o       ( ctrl_rsp    )
  );

endmodule

// ==== logic/ext_playground.sv ====
// Offsets 0 to 2 only; the add count wraps silently and the overflow flag clears only through offset 1
`include "soc_cfg.svh"

module ext_playground (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  soc_pkg::bus_req_t slv_req_i,
  output soc_pkg::bus_rsp_t slv_rsp_o,
  output logic              ovf_o
);

  logic [`SOC_REGION_LSB-1:0] offset;
  logic [`SOC_EXT_CNT_W-1:0]  cnt_q;
  logic                       add_carry;
  logic                       do_add;
  logic                       do_clr;
  logic                       bad_acc;
  logic                       ovf_q;
  logic                       rsp_valid_q;
  logic                       rsp_err_q;

  soc_pkg::data_t acc_q;
  soc_pkg::data_t add_sum;
  soc_pkg::data_t rd_data;
  soc_pkg::data_t rdata_q;

  assign offset = slv_req_i.addr[`SOC_REGION_LSB-1:0];
  assign do_add = slv_req_i.valid && slv_req_i.write && offset == 0;
  assign do_clr = slv_req_i.valid && slv_req_i.write && offset == 1;

  // Count register is read only
  assign bad_acc = (offset > 2) || (slv_req_i.write && offset == 2);

  assign {add_carry, add_sum} = acc_q + slv_req_i.wdata;

  //////////////////////////////////////////////////////////////////////
  // Accumulator state
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      acc_q <= '0;
      cnt_q <= '0;
      ovf_q <= 1'b0;
    end else if (do_clr) begin
      acc_q <= '0;
      cnt_q <= '0;
      ovf_q <= 1'b0;
    end else if (do_add) begin
      acc_q <= add_sum;
      cnt_q <= cnt_q + 1'b1;
      // Sticky until the next clear
      ovf_q <= ovf_q | add_carry;
    end
  end

  assign ovf_o = ovf_q;

  // Read mux
  always_comb begin
    case (offset)
      0:       rd_data = acc_q;
      2:       rd_data = soc_pkg::data_t'(cnt_q);
      default: rd_data = '0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Response
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
      rsp_err_q   <= 1'b0;
    end else begin
      rsp_valid_q <= slv_req_i.valid;
      rsp_err_q   <= slv_req_i.valid & bad_acc;
    end
  end

  always_ff @(posedge clk_i) begin
    if (slv_req_i.valid) begin
      rdata_q <= (slv_req_i.write || bad_acc) ? '0 : rd_data;
    end
  end

  always_comb begin
    slv_rsp_o.valid = rsp_valid_q;
    slv_rsp_o.err   = rsp_err_q;
    slv_rsp_o.rdata = rdata_q;
  end

endmodule

// ==== logic/soc_fixture_top.sv ====
// Single external slave only; the extension block answers the whole external region
module soc_fixture_top (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                rtc_i,
  input  soc_pkg::boot_mode_t boot_mode_i,
  input  soc_pkg::bus_req_t   host_req_i,
  output soc_pkg::bus_rsp_t   host_rsp_o,
  output logic                ext_ovf_o
);

  // External slave port
  soc_pkg::bus_req_t ext_slv_req;
  soc_pkg::bus_rsp_t ext_slv_rsp;

  soc_core soc_core_i (
    .clk_i         ( clk_i       ),
    .rst_n_i       ( rst_n_i     ),
    .rtc_i         ( rtc_i       ),
    .boot_mode_i   ( boot_mode_i ),
    .host_req_i    ( host_req_i  ),
    .host_rsp_o    ( host_rsp_o  ),
    .ext_slv_req_o ( ext_slv_req ),
    .ext_slv_rsp_i ( ext_slv_rsp )
  );

  // Extension block on the external slave port
  ext_playground ext_playground_i (
    .clk_i     ( clk_i       ),
    .rst_n_i   ( rst_n_i     ),
    .slv_req_i ( ext_slv_req ),
    .slv_rsp_o ( ext_slv_rsp ),
    .ovf_o     ( ext_ovf_o   )
  );

endmodule

// ==== bench/tb_soc_fixture.sv ====
// One request per cycle from a fixed table and each response checked one cycle later with no stalls
`include "soc_cfg.svh"

module tb_soc_fixture;

  localparam int CLK_HALF   = 20;
  localparam int CLK_PERIOD = 40;
  localparam int RST_CYCLES = 5;
  localparam int DRV_DELAY  = 2;

  // One row of the stimulus table
  typedef struct packed {
    logic           write;
    soc_pkg::addr_t addr;
    soc_pkg::data_t wdata;
    logic           rtc;
    soc_pkg::data_t exp_rdata;
    logic           exp_err;
    logic           exp_ovf;
  } entry_t;

  logic                clk_i;
  logic                rst_n_i;
  logic                rtc_i;
  soc_pkg::boot_mode_t boot_mode_i;
  soc_pkg::bus_req_t   host_req_i;
  soc_pkg::bus_rsp_t   host_rsp_o;
  logic                ext_ovf_o;

  entry_t         table_q[$];
  soc_pkg::data_t mem_model [`SOC_MEM_DEPTH];
  integer         seed;
  int             n_pass;
  int             n_fail;
  logic           table_ready;

  soc_fixture_top soc_fixture_top_i (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .rtc_i       ( rtc_i       ),
    .boot_mode_i ( boot_mode_i ),
    .host_req_i  ( host_req_i  ),
    .host_rsp_o  ( host_rsp_o  ),
    .ext_ovf_o   ( ext_ovf_o   )
  );

  always #CLK_HALF clk_i = ~clk_i;

  //////////////////////////////////////////////////////////////////////
  // Table construction
  //////////////////////////////////////////////////////////////////////

  task automatic add_entry(input logic write, input soc_pkg::addr_t addr,
                           input soc_pkg::data_t wdata, input logic rtc,
                           input soc_pkg::data_t exp_rdata, input logic exp_err,
                           input logic exp_ovf);
    entry_t e;
    e.write     = write;
    e.addr      = addr;
    e.wdata     = wdata;
    e.rtc       = rtc;
    e.exp_rdata = exp_rdata;
    e.exp_err   = exp_err;
    e.exp_ovf   = exp_ovf;
    table_q.push_back(e);
  endtask

  // Random word into the memory and into the model
  task automatic mem_write(input logic [`SOC_MEM_IDX_W-1:0] idx);
    soc_pkg::data_t word;
    word = $random(seed);
    mem_model[idx] = word;
    add_entry(1'b1, soc_pkg::addr_t'(idx), word, 1'b0, '0, 1'b0, 1'b0);
  endtask

  task automatic mem_read(input logic [`SOC_MEM_IDX_W-1:0] idx);
    add_entry(1'b0, soc_pkg::addr_t'(idx), '0, 1'b0, mem_model[idx], 1'b0, 1'b0);
  endtask

  task automatic build_table();
    int k;
    // Scratch memory with index 0x10 written twice
    mem_write(8'h03);
    mem_write(8'h10);
    mem_write(8'h7F);
    mem_write(8'hFF);
    mem_write(8'h10);
    mem_read(8'h10);
    mem_read(8'h03);
    mem_read(8'hFF);
    mem_read(8'h7F);

    // Control registers
    add_entry(1'b0, 16'h1000, '0, 1'b0, `SOC_ID_VALUE, 1'b0, 1'b0);
    add_entry(1'b0, 16'h1001, '0, 1'b0, 32'd2, 1'b0, 1'b0);
    add_entry(1'b1, 16'h1002, 32'hA5A5_0F0F, 1'b0, '0, 1'b0, 1'b0);
    add_entry(1'b0, 16'h1002, '0, 1'b0, 32'hA5A5_0F0F, 1'b0, 1'b0);
    add_entry(1'b1, 16'h1000, 32'h1234_5678, 1'b0, '0, 1'b0, 1'b0);
    add_entry(1'b0, 16'h1000, '0, 1'b0, `SOC_ID_VALUE, 1'b0, 1'b0);
    add_entry(1'b0, 16'h1005, '0, 1'b0, '0, 1'b1, 1'b0);

    // Three RTC pulses of four cycles per level
    for (k = 0; k < 3; k++) begin
      repeat (4) add_entry(1'b0, 16'h1001, '0, 1'b1, 32'd2, 1'b0, 1'b0);
      repeat (4) add_entry(1'b0, 16'h1001, '0, 1'b0, 32'd2, 1'b0, 1'b0);
    end
    add_entry(1'b0, 16'h1003, '0, 1'b0, 32'd3, 1'b0, 1'b0);

    // Unmapped addresses
    add_entry(1'b0, 16'h3000, '0, 1'b0, '0, 1'b1, 1'b0);
    add_entry(1'b1, 16'hF00A, 32'hDEAD_BEEF, 1'b0, '0, 1'b1, 1'b0);
    add_entry(1'b0, 16'h0100, '0, 1'b0, '0, 1'b1, 1'b0);

    // Accumulator and add count
    add_entry(1'b1, 16'h2000, 32'd5, 1'b0, '0, 1'b0, 1'b0);
    add_entry(1'b1, 16'h2000, 32'd7, 1'b0, '0, 1'b0, 1'b0);
    add_entry(1'b0, 16'h2000, '0, 1'b0, 32'd12, 1'b0, 1'b0);
    add_entry(1'b0, 16'h2002, '0, 1'b0, 32'd2, 1'b0, 1'b0);
    add_entry(1'b1, 16'h2001, '0, 1'b0, '0, 1'b0, 1'b0);
    add_entry(1'b0, 16'h2000, '0, 1'b0, 32'd0, 1'b0, 1'b0);
    add_entry(1'b0, 16'h2002, '0, 1'b0, 32'd0, 1'b0, 1'b0);
    add_entry(1'b1, 16'h2002, 32'd9, 1'b0, '0, 1'b1, 1'b0);

    // Overflow flag is sticky until a clear
    add_entry(1'b1, 16'h2001, '0, 1'b0, '0, 1'b0, 1'b0);
    add_entry(1'b1, 16'h2000, 32'hFFFF_FFF0, 1'b0, '0, 1'b0, 1'b0);
    add_entry(1'b1, 16'h2000, 32'h0000_0020, 1'b0, '0, 1'b0, 1'b1);
    add_entry(1'b0, 16'h2000, '0, 1'b0, 32'h0000_0010, 1'b0, 1'b1);
    add_entry(1'b0, 16'h2002, '0, 1'b0, 32'd2, 1'b0, 1'b1);
    add_entry(1'b1, 16'h2001, '0, 1'b0, '0, 1'b0, 1'b0);
    add_entry(1'b0, 16'h2000, '0, 1'b0, 32'd0, 1'b0, 1'b0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Drive and check
  //////////////////////////////////////////////////////////////////////

  task automatic drive_entry(input entry_t e);
    host_req_i.valid = 1'b1;
    host_req_i.write = e.write;
    host_req_i.addr  = e.addr;
    host_req_i.wdata = e.wdata;
    rtc_i            = e.rtc;
  endtask

  task automatic drive_idle();
    host_req_i = '0;
  endtask

  task automatic check_response(input int num, input entry_t e);
    logic ok;
    ok = 1'b1;
    if (host_rsp_o.valid !== 1'b1) begin
      $display("Test %0d: no valid response one cycle after the request, time %0t",
               num, $time);
      ok = 1'b0;
    end else begin
      if (host_rsp_o.rdata !== e.exp_rdata) begin
        $display("MISMATCH time=%0t signal=host_rsp_o.rdata expected=%h actual=%h",
                 $time, e.exp_rdata, host_rsp_o.rdata);
        ok = 1'b0;
      end
      if (host_rsp_o.err !== e.exp_err) begin
        $display("MISMATCH time=%0t signal=host_rsp_o.err expected=%b actual=%b",
                 $time, e.exp_err, host_rsp_o.err);
        ok = 1'b0;
      end
    end
    if (ext_ovf_o !== e.exp_ovf) begin
      $display("MISMATCH time=%0t signal=ext_ovf_o expected=%b actual=%b",
               $time, e.exp_ovf, ext_ovf_o);
      ok = 1'b0;
    end
    if (ok) begin
      n_pass++;
      $display("Test %0d %s addr %h: ok", num, e.write ? "write" : "read", e.addr);
    end else begin
      n_fail++;
      $display("Test %0d %s addr %h: failed", num, e.write ? "write" : "read", e.addr);
    end
  endtask

  // No response may appear in a cycle that follows no request
  task automatic check_idle(input string what);
    if (host_rsp_o.valid !== 1'b0) begin
      $display("Idle check %s: response valid without a request, time %0t", what, $time);
      n_fail++;
    end else begin
      n_pass++;
      $display("Idle check %s: ok", what);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    clk_i       = 1'b0;
    rst_n_i     = 1'b0;
    rtc_i       = 1'b0;
    boot_mode_i = 2'b10;
    host_req_i  = '0;
    seed        = 32'h435e;
    n_pass      = 0;
    n_fail      = 0;
    table_ready = 1'b0;

    build_table();
    table_ready = 1'b1;

    repeat (RST_CYCLES) @(posedge clk_i);
    #DRV_DELAY;
    rst_n_i = 1'b1;

    // Response of row i-1 is registered at the edge that samples row i
    // First and last passes see an idle bus
    for (int i = 0; i <= table_q.size() + 1; i++) begin
      @(posedge clk_i);
      #DRV_DELAY;
      if (i == 0) begin
        check_idle("after reset");
      end else if (i == table_q.size() + 1) begin
        check_idle("after the last request");
      end else begin
        check_response(i - 1, table_q[i - 1]);
      end
      if (i < table_q.size()) begin
        drive_entry(table_q[i]);
      end else begin
        drive_idle();
      end
    end

    $display("Tests run %0d, passed %0d, failed %0d", n_pass + n_fail, n_pass, n_fail);
    if (n_fail == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Watchdog sized from the table
  initial begin
    wait (table_ready === 1'b1);
    #((table_q.size() + RST_CYCLES + 20) * CLK_PERIOD);
    $display("Watchdog expired before all table rows were checked");
    $display("Simulation failed");
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+include
logic/soc_pkg.sv
logic/soc_scratch_mem.sv
logic/soc_ctrl_regs.sv
logic/soc_core.sv
logic/ext_playground.sv
logic/soc_fixture_top.sv
bench/tb_soc_fixture.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= tb_soc_fixture
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Simulation passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, search $(LOG) for the pass message"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
	  echo "test target: pass"; \
	else \
	  echo "test target: pass message not found in $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
